//--- Bender.yml
package:
  name: mem_port_hub

sources:
  - files:
      - source/mem_hub_pkg.sv
      - source/fifo_2word_fwft.sv
      - source/port_round_robin.sv
      - source/shared_ram.sv
      - source/read_return_router.sv
      - source/mem_port_hub.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/mem_port_hub_tb.sv

//--- build.f
+incdir+tests
source/mem_hub_pkg.sv
source/fifo_2word_fwft.sv
source/port_round_robin.sv
source/shared_ram.sv
source/read_return_router.sv
source/mem_port_hub.sv
tests/mem_port_hub_tb.sv

//--- source/fifo_2word_fwft.sv
// two-word first-word-fall-through FIFO, payload set by a type parameter

`timescale 1ns/1ps

module fifo_2word_fwft #(
  parameter type payload_t = logic [7:0]  // any packed payload
) (
  input  logic     clk,
  input  logic     reset,

  input  logic     shift_in,              // load data_in
  input  logic     shift_out,             // drop the head word, only while not empty
  input  payload_t data_in,

  output logic     fifo_not_empty,        // data_out holds a valid word
  output logic     fifo_full,             // both words held and no shift_out this cycle
  output payload_t data_out               // head word, valid with fifo_not_empty
);

  payload_t source;                       // next value for the output register
  logic     source_ready;                 // source holds a real word
  payload_t memory;                       // elastic second word
  logic     memory_filled;
  logic     data_out_ready;

  // the elastic word always has priority over fresh input
  always_comb begin
    source         = memory_filled ? memory : data_in;
    source_ready   = memory_filled ? 1'b1   : shift_in;
    fifo_not_empty = data_out_ready;
    fifo_full      = memory_filled && !shift_out;
  end

  // ************************************************************************
  // occupancy flags
  // ************************************************************************

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      data_out_ready <= 1'b0;
      memory_filled  <= 1'b0;
    end else begin
      if (shift_out || !data_out_ready)   // keep loading until a word is shown
        data_out_ready <= source_ready;
      if (shift_in && data_out_ready)     // output busy, word lands in elastic slot
        memory_filled <= !shift_out || memory_filled;
      else if (shift_out)
        memory_filled <= 1'b0;            // elastic word moved forward
    end
  end

  // ************************************************************************
  // word storage
  // ************************************************************************

  always_ff @(posedge clk) begin
    if (shift_out || !data_out_ready)
      data_out <= source;                 // fall through or advance
    if (shift_in && data_out_ready)
      memory <= data_in;
  end

endmodule

//--- source/mem_hub_pkg.sv
// shared widths, port index type and packed command/read payload types for the hub

package mem_hub_pkg;

  // ************************************************************************
  // widths
  // ************************************************************************

  localparam int data_w        = 16;                    // bits per ram word
  localparam int addr_w        = 8;                     // word address, 256 words
  localparam int num_ports_max = 4;                     // default client port count

  localparam int port_idx_w    = $clog2(num_ports_max); // bits to name one port

  // ************************************************************************
  // types
  // ************************************************************************

  // port number, carried with a read so the return knows its owner
  typedef logic [port_idx_w-1:0] port_idx_t;

  // one client command, 1 + 8 + 16 = 25 bits
  typedef struct packed {
    logic              is_write;                        // 1 = write, 0 = read
    logic [addr_w-1:0] addr;                            // word address
    logic [data_w-1:0] wdata;                           // write data, don't care on reads
  } mem_cmd_t;

  // word handed back to a client on a read
  typedef logic [data_w-1:0] rd_word_t;

endpackage

//--- source/mem_port_hub.sv
// top level of the shared-memory hub: per-port FIFOs, arbiter, RAM and return router

`timescale 1ns/1ps

module mem_port_hub #(
  parameter int num_ports = mem_hub_pkg::num_ports_max
) (
  input  logic                                         clk,
  input  logic                                         reset,

  // command side, one lane per port
  input  logic [num_ports-1:0]                         cmd_push,
  input  logic [num_ports-1:0]                         cmd_is_write,
  input  logic [num_ports-1:0][mem_hub_pkg::addr_w-1:0] cmd_addr,
  input  logic [num_ports-1:0][mem_hub_pkg::data_w-1:0] cmd_wdata,
  output logic [num_ports-1:0]                         cmd_full,     // do not push while high

  // read return side
  output logic [num_ports-1:0]                         rd_not_empty, // rd_data valid
  output logic [num_ports-1:0][mem_hub_pkg::data_w-1:0] rd_data,
  input  logic [num_ports-1:0]                         rd_pop
);

  localparam int ram_depth = 2 ** mem_hub_pkg::addr_w;  // full address space

  // ************************************************************************
  // internal nets
  // ************************************************************************

  mem_hub_pkg::mem_cmd_t [num_ports-1:0] push_cmd;      // packed client command
  mem_hub_pkg::mem_cmd_t [num_ports-1:0] head_cmd;      // command FIFO heads
  logic [num_ports-1:0]                  cmd_avail;
  logic [num_ports-1:0]                  cmd_grant;
  logic [num_ports-1:0]                  rd_full;
  logic [num_ports-1:0]                  rd_shift_in;
  logic [num_ports-1:0]                  read_done;

  logic                   ram_en;
  mem_hub_pkg::mem_cmd_t  ram_cmd;
  mem_hub_pkg::port_idx_t ram_port;
  logic                   ret_valid;
  mem_hub_pkg::port_idx_t ret_port;
  mem_hub_pkg::rd_word_t  ret_data;

  // ************************************************************************
  // per-port queues
  // ************************************************************************

  for (genvar p = 0; p < num_ports; p++) begin : g_port

    always_comb begin
      push_cmd[p].is_write = cmd_is_write[p];
      push_cmd[p].addr     = cmd_addr[p];
      push_cmd[p].wdata    = cmd_wdata[p];
    end

    // command queue, head is popped by the arbiter grant
    fifo_2word_fwft #(
      .payload_t      (mem_hub_pkg::mem_cmd_t)
    ) u_cmd_fifo (
      .clk            (clk),
      .reset          (reset),
      .shift_in       (cmd_push[p]),
      .shift_out      (cmd_grant[p]),
      .data_in        (push_cmd[p]),
      .fifo_not_empty (cmd_avail[p]),
      .fifo_full      (cmd_full[p]),
      .data_out       (head_cmd[p])
    );

    // read-return queue, all ports see ret_data, only the tagged one loads
    fifo_2word_fwft #(
      .payload_t      (mem_hub_pkg::rd_word_t)
    ) u_rd_fifo (
      .clk            (clk),
      .reset          (reset),
      .shift_in       (rd_shift_in[p]),
      .shift_out      (rd_pop[p]),
      .data_in        (ret_data),
      .fifo_not_empty (rd_not_empty[p]),
      .fifo_full      (rd_full[p]),
      .data_out       (rd_data[p])
    );

  end

  // ************************************************************************
  // arbiter, ram and return path
  // ************************************************************************

  port_round_robin #(
    .num_ports (num_ports)
  ) u_arb (
    .clk       (clk),
    .reset     (reset),
    .cmd_avail (cmd_avail),
    .head_cmd  (head_cmd),
    .rd_full   (rd_full),
    .read_done (read_done),
    .cmd_grant (cmd_grant),
    .ram_en    (ram_en),
    .ram_cmd   (ram_cmd),
    .ram_port  (ram_port)
  );

  shared_ram #(
    .depth     (ram_depth)
  ) u_ram (
    .clk       (clk),
    .reset     (reset),
    .ram_en    (ram_en),
    .ram_cmd   (ram_cmd),
    .ram_port  (ram_port),
    .ret_valid (ret_valid),
    .ret_port  (ret_port),
    .ret_data  (ret_data)
  );

  read_return_router #(
    .num_ports   (num_ports)
  ) u_router (
    .ret_valid   (ret_valid),
    .ret_port    (ret_port),
    .rd_shift_in (rd_shift_in),
    .read_done   (read_done)
  );

endmodule

//--- source/port_round_robin.sv
// round-robin arbiter over the port command FIFOs with per-port outstanding-read tracking

`timescale 1ns/1ps

module port_round_robin #(
  parameter int num_ports = mem_hub_pkg::num_ports_max
) (
  input  logic                                 clk,
  input  logic                                 reset,

  input  logic [num_ports-1:0]                 cmd_avail,   // command FIFO not empty
  input  mem_hub_pkg::mem_cmd_t [num_ports-1:0] head_cmd,   // head word of each FIFO
  input  logic [num_ports-1:0]                 rd_full,     // read FIFO full
  input  logic [num_ports-1:0]                 read_done,   // read word returned

  output logic [num_ports-1:0]                 cmd_grant,   // pops the winning FIFO
  output logic                                 ram_en,
  output mem_hub_pkg::mem_cmd_t                ram_cmd,
  output mem_hub_pkg::port_idx_t               ram_port
);

  logic [num_ports-1:0]   eligible;       // request masked by read rules
  logic [num_ports-1:0]   rd_outstanding; // one read in flight per port
  mem_hub_pkg::port_idx_t ptr;            // first port to look at
  mem_hub_pkg::port_idx_t winner;
  logic                   grant_found;

  // ************************************************************************
  // eligibility and search
  // ************************************************************************

  // a read needs room waiting for it in the read FIFO, writes always go
  always_comb begin
    for (int p = 0; p < num_ports; p++)
      eligible[p] = cmd_avail[p] &&
                    (head_cmd[p].is_write || (!rd_outstanding[p] && !rd_full[p]));
  end

  always_comb begin
    int idx;
    cmd_grant   = '0;
    winner      = ptr;                    // harmless default when idle
    grant_found = 1'b0;
    for (int i = 0; i < num_ports; i++) begin
      idx = int'(ptr) + i;                // walk ptr, ptr+1, ... with wrap
      if (idx >= num_ports)
        idx = idx - num_ports;
      if (!grant_found && eligible[idx]) begin
        grant_found = 1'b1;
        winner      = mem_hub_pkg::port_idx_t'(idx);
      end
    end
    if (grant_found)
      cmd_grant[winner] = 1'b1;           // single hot bit at most
  end

  assign ram_en   = grant_found;
  assign ram_cmd  = head_cmd[winner];
  assign ram_port = winner;

  // ************************************************************************
  // pointer and outstanding reads
  // ************************************************************************

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ptr            <= '0;
      rd_outstanding <= '0;
    end else begin
      if (grant_found)                    // next search starts past the winner
        ptr <= (int'(winner) == num_ports - 1) ? '0 : winner + 1'b1;
      for (int p = 0; p < num_ports; p++) begin
        if (cmd_grant[p] && !head_cmd[p].is_write)
          rd_outstanding[p] <= 1'b1;      // set on read grant
        else if (read_done[p])
          rd_outstanding[p] <= 1'b0;      // word is in the read FIFO
      end
    end
  end

endmodule

//--- source/read_return_router.sv
// decodes the read return tag into per-port read FIFO strobes and read-done pulses

`timescale 1ns/1ps

module read_return_router #(
  parameter int num_ports = mem_hub_pkg::num_ports_max
) (
  input  logic                   ret_valid,    // word on ret_data this cycle
  input  mem_hub_pkg::port_idx_t ret_port,     // owner of that word

  output logic [num_ports-1:0]   rd_shift_in,  // load strobe per read FIFO
  output logic [num_ports-1:0]   read_done     // to arbiter, ends the outstanding read
);

  logic [num_ports-1:0] port_hit;

  // tag decode, one hot when valid
  always_comb begin
    port_hit = '0;
    for (int p = 0; p < num_ports; p++)
      port_hit[p] = ret_valid && (int'(ret_port) == p);
  end

  assign rd_shift_in = port_hit;
  assign read_done   = port_hit;   // same cycle the word is loaded

endmodule

//--- source/shared_ram.sv
// single-port synchronous RAM, one-cycle read latency, port tag carried with read data

`timescale 1ns/1ps

module shared_ram #(
  parameter int depth = 2 ** mem_hub_pkg::addr_w  // words
) (
  input  logic                   clk,
  input  logic                   reset,

  input  logic                   ram_en,          // granted command this cycle
  input  mem_hub_pkg::mem_cmd_t  ram_cmd,
  input  mem_hub_pkg::port_idx_t ram_port,        // who asked

  output logic                   ret_valid,       // one cycle after a read grant
  output mem_hub_pkg::port_idx_t ret_port,
  output mem_hub_pkg::rd_word_t  ret_data
);

  mem_hub_pkg::rd_word_t mem [depth];            // word array

  logic do_write;
  logic do_read;

  assign do_write = ram_en &&  ram_cmd.is_write;
  assign do_read  = ram_en && !ram_cmd.is_write;

  // ************************************************************************
  // array and registered read path
  // ************************************************************************

  always_ff @(posedge clk) begin
    if (do_write)
      mem[ram_cmd.addr] <= ram_cmd.wdata;        // stored at end of grant cycle
    if (do_read) begin
      ret_data <= mem[ram_cmd.addr];             // old contents, no write in same cycle
      ret_port <= ram_port;                      // tag rides along
    end
  end

  // return strobe
  always_ff @(posedge clk or posedge reset) begin
    if (reset)
      ret_valid <= 1'b0;
    else
      ret_valid <= do_read;                      // single-cycle pulse per read
  end

endmodule

//--- tests/tb_support.svh
// testbench constants, error counters, lcg random source, value compare and failure report
`ifndef tb_support_svh
`define tb_support_svh

// ***************************************************************************
// constants
// ***************************************************************************

localparam logic [31:0] lcg_seed     = 32'h4f6cc6e7;
localparam int          clk_period   = 20;     // ns
localparam int          reset_cycles = 10;
localparam int          wait_limit   = 20000;  // cycles before any wait gives up
localparam int          fair_cycles  = 400;    // length of the fairness window
localparam int          fair_slack   = 2;      // allowed spread of accepted pushes

int          error_count = 0;
int          check_count = 0;
logic [31:0] lcg_state   = lcg_seed;

// ***************************************************************************
// random numbers
// ***************************************************************************

// numerical recipes multiplier and increment, full 32-bit period
function automatic logic [31:0] next_rand();
  lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
  return lcg_state;
endfunction

// low lcg bits cycle quickly, so draw from the upper half
function automatic int rand_below(int n);
  logic [31:0] r;
  r = next_rand();
  return int'(r[31:16]) % n;
endfunction

function automatic logic [15:0] rand_word();
  logic [31:0] r;
  r = next_rand();
  return r[31:16];
endfunction

// ***************************************************************************
// checks
// ***************************************************************************

task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
  check_count++;
  if (expected !== actual) begin
    error_count++;
    $display("ERR %s expected %h actual %h at %0t", name, expected, actual, $time);
  end
endtask

task automatic report_failure(string what);
  error_count++;
  $display("failure: %s at %0t", what, $time);
endtask

`endif

//--- tests/mem_port_hub_tb.sv
// clock, reset, per-port random traffic, reference memory model and checks for the hub

`timescale 1ns/1ps

module mem_port_hub_tb;

  localparam int num_ports = mem_hub_pkg::num_ports_max;
  localparam int aw        = mem_hub_pkg::addr_w;
  localparam int dw        = mem_hub_pkg::data_w;

  `include "tb_support.svh"

  logic                          clk;
  logic                          reset;
  logic [num_ports-1:0]          cmd_push;
  logic [num_ports-1:0]          cmd_is_write;
  logic [num_ports-1:0][aw-1:0]  cmd_addr;
  logic [num_ports-1:0][dw-1:0]  cmd_wdata;
  logic [num_ports-1:0]          cmd_full;
  logic [num_ports-1:0]          rd_not_empty;
  logic [num_ports-1:0][dw-1:0]  rd_data;
  logic [num_ports-1:0]          rd_pop;

  mem_hub_pkg::rd_word_t ref_mem [2**aw];       // mirror of the ram
  mem_hub_pkg::mem_cmd_t pend_q [num_ports][$]; // commands not yet pushed
  mem_hub_pkg::rd_word_t exp_q  [num_ports][$]; // read words still owed per port
  int                    accepted [num_ports];  // pushes taken by each port
  logic [num_ports-1:0]  push_prev;             // pushed in the cycle just ended
  logic [num_ports-1:0]  pop_prev;
  logic [num_ports-1:0]  pop_en;                // client willing to pop
  int                    push_pct;
  int                    pop_pct;

  mem_port_hub #(
    .num_ports    (num_ports)
  ) dut (
    .clk          (clk),
    .reset        (reset),
    .cmd_push     (cmd_push),
    .cmd_is_write (cmd_is_write),
    .cmd_addr     (cmd_addr),
    .cmd_wdata    (cmd_wdata),
    .cmd_full     (cmd_full),
    .rd_not_empty (rd_not_empty),
    .rd_data      (rd_data),
    .rd_pop       (rd_pop)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // ***************************************************************************
  // stimulus helpers
  // ***************************************************************************

  function automatic mem_hub_pkg::mem_cmd_t make_cmd(int p, logic is_write, int low,
                                                     logic [dw-1:0] wdata);
    mem_hub_pkg::mem_cmd_t c;
    c.is_write = is_write;
    c.addr     = {p[1:0], low[aw-3:0]};          // top bits select the port's quarter
    c.wdata    = wdata;
    return c;
  endfunction

  task automatic queue_random(int p, int n);
    logic wr;
    for (int i = 0; i < n; i++) begin
      wr = rand_below(100) < 50;
      pend_q[p].push_back(make_cmd(p, wr, rand_below(32), rand_word()));
    end
  endtask

  // sample flags of the cycle just ended and drive the next one
  task automatic step_cycle();
    mem_hub_pkg::mem_cmd_t c;
    @(posedge clk);
    for (int p = 0; p < num_ports; p++) begin
      // no push right after a push, so a fifo seen with room still has room
      if (pend_q[p].size() > 0 && !cmd_full[p] && !push_prev[p] &&
          rand_below(100) < push_pct) begin
        c = pend_q[p].pop_front();
        cmd_push[p]     <= 1'b1;
        cmd_is_write[p] <= c.is_write;
        cmd_addr[p]     <= c.addr;
        cmd_wdata[p]    <= c.wdata;
        if (c.is_write)
          ref_mem[c.addr] = c.wdata;           // model follows push order
        else
          exp_q[p].push_back(ref_mem[c.addr]);
        accepted[p]++;
        push_prev[p] = 1'b1;
      end else begin
        cmd_push[p]  <= 1'b0;
        push_prev[p] = 1'b0;
      end
      // head word is stable while not empty and unpopped
      if (rd_not_empty[p] && !pop_prev[p] && pop_en[p] && rand_below(100) < pop_pct) begin
        if (exp_q[p].size() == 0)
          report_failure($sformatf("port %0d returned a word that was never requested", p));
        else
          check_value($sformatf("rd_data[%0d]", p), exp_q[p].pop_front(), rd_data[p]);
        rd_pop[p]   <= 1'b1;
        pop_prev[p] = 1'b1;
      end else begin
        rd_pop[p]   <= 1'b0;
        pop_prev[p] = 1'b0;
      end
    end
  endtask

  function automatic logic ports_idle(logic [num_ports-1:0] mask);
    for (int p = 0; p < num_ports; p++)
      if (mask[p] && (pend_q[p].size() != 0 || exp_q[p].size() != 0))
        return 1'b0;
    return 1'b1;
  endfunction

  // ***************************************************************************
  // waits and end of run
  // ***************************************************************************

  task automatic end_run();
    $display("checks: %0d  errors: %0d", check_count, error_count);
    if (error_count == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  endtask

  task automatic drain_ports(logic [num_ports-1:0] mask, string what);
    int timer = 0;
    while (!ports_idle(mask) && timer < wait_limit) begin
      step_cycle();
      timer++;
    end
    if (!ports_idle(mask)) begin
      report_failure({"timeout while draining ", what});
      end_run();
    end
  endtask

  // full_flag high waits on cmd_full and low on rd_not_empty
  task automatic wait_until_set(logic full_flag, int p, string what);
    int timer = 0;
    while (!(full_flag ? cmd_full[p] : rd_not_empty[p]) && timer < wait_limit) begin
      step_cycle();
      timer++;
    end
    if (!(full_flag ? cmd_full[p] : rd_not_empty[p])) begin
      report_failure({"timeout waiting for ", what});
      end_run();
    end
  endtask

  // every command queue has room again
  task automatic wait_cmd_room(string what);
    int timer = 0;
    while (cmd_full != '0 && timer < wait_limit) begin
      step_cycle();
      timer++;
    end
    if (cmd_full != '0) begin
      report_failure({"timeout waiting for ", what});
      end_run();
    end
  endtask

  // ***************************************************************************
  // test sequence
  // ***************************************************************************

  initial begin
    reset        <= 1'b1;
    cmd_push     = '0;
    cmd_is_write = '0;
    cmd_addr     = '0;
    cmd_wdata    = '0;
    rd_pop       = '0;
    push_prev    = '0;
    pop_prev     = '0;
    pop_en       = '1;
    push_pct     = 100;
    pop_pct      = 100;
    for (int a = 0; a < 2**aw; a++)
      ref_mem[a] = '0;
    for (int p = 0; p < num_ports; p++)
      accepted[p] = 0;

    // flags stay low through reset and just after
    for (int i = 0; i < reset_cycles; i++) begin
      @(posedge clk);
      check_value("cmd_full", '0, cmd_full);
      check_value("rd_not_empty", '0, rd_not_empty);
    end
    reset <= 1'b0;
    step_cycle();
    check_value("cmd_full", '0, cmd_full);
    check_value("rd_not_empty", '0, rd_not_empty);

    // port 0 write then read with the word falling through before any pop
    pop_en = '0;
    pend_q[0].push_back(make_cmd(0, 1'b1, 5, 16'h5a3c));
    pend_q[0].push_back(make_cmd(0, 1'b0, 5, '0));
    wait_until_set(1'b0, 0, "read data on port 0");
    check_value("rd_data[0]", 32'h5a3c, rd_data[0]);
    pop_en = '1;
    drain_ports('1, "single read on port 0");

    // zero every region and then run mixed random traffic with random pops
    for (int p = 0; p < num_ports; p++)
      for (int a = 0; a < 64; a++)
        pend_q[p].push_back(make_cmd(p, 1'b1, a, '0));
    drain_ports('1, "zero fill");
    push_pct = 60;
    pop_pct  = 50;
    for (int p = 0; p < num_ports; p++)
      queue_random(p, 100);
    drain_ports('1, "random traffic");

    // port 2 reads without popping until its command queue backs up
    for (int a = 0; a < 4; a++)
      pend_q[2].push_back(make_cmd(2, 1'b1, a, rand_word()));
    for (int i = 0; i < 8; i++)
      pend_q[2].push_back(make_cmd(2, 1'b0, i % 4, '0));
    for (int p = 0; p < num_ports; p++)
      if (p != 2)
        queue_random(p, 40);
    pop_en = 4'b1011;
    wait_until_set(1'b1, 2, "cmd_full on stalled port 2");
    drain_ports(4'b1011, "other ports while port 2 stalls");
    check_value("rd_not_empty[2]", 32'h1, rd_not_empty[2]);
    pop_en = '1;
    drain_ports('1, "port 2 after popping resumes");

    // every port pushes writes whenever it can
    push_pct = 100;
    for (int p = 0; p < num_ports; p++) begin
      accepted[p] = 0;
      for (int i = 0; i < 200; i++)
        pend_q[p].push_back(make_cmd(p, 1'b1, rand_below(64), rand_word()));
    end
    for (int i = 0; i < fair_cycles; i++)
      step_cycle();
    for (int p = 0; p < num_ports; p++)
      pend_q[p].delete();
    for (int a = 0; a < num_ports; a++)
      for (int b = a + 1; b < num_ports; b++)
        if (accepted[a] - accepted[b] > fair_slack || accepted[b] - accepted[a] > fair_slack)
          report_failure($sformatf("unfair service, port %0d took %0d pushes and port %0d %0d",
                                   a, accepted[a], b, accepted[b]));

    // queued writes retire and no read word is left behind
    wait_cmd_room("command queue room after the fairness window");
    check_value("rd_not_empty", '0, rd_not_empty);
    end_run();
  end

endmodule
